/* all.f */
+incdir+include
hw/nts_pkg.sv
hw/trap_arbiter.sv
hw/nts_stack.sv
hw/nts_ret_ctrl.sv
hw/nts_top.sv
tb/nts_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= nts_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '$(PASS_MSG)' $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/nts_tb.sv */
`timescale 1ns/1ps

`include "nts_settings.svh"

module nts_tb
  import nts_pkg::*;
();

  localparam int SYNC            = `NTS_SYNC_STAGES;
  localparam int DEPTH           = `NTS_DEPTH;
  localparam int WAIT_LIMIT      = 20;
  localparam int RAND_CYCLES     = 400;
  localparam int TEST_CYCLES     = 300 + RAND_CYCLES + 16 * DEPTH;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 1000;

  typedef struct packed {
    trap_cause_e cause;
    xlen_t       epc;
    xlen_t       status;
  } ctx_t;

  logic        clk;
  logic        rst_i;
  logic        ext_irq_a_i;
  logic        sft_irq_a_i;
  logic        tmr_irq_a_i;
  logic        mie_i;
  logic        mret_i;
  xlen_t       pc_i = '0;
  xlen_t       mstatus_i = '0;
  logic        trap_o;
  trap_cause_e trap_cause_o;
  logic        ret_valid_o;
  xlen_t       ret_epc_o;
  trap_cause_e ret_cause_o;
  xlen_t       ret_status_o;
  logic        ret_err_o;
  logic        nts_full_o;
  depth_t      nts_depth_o;

  logic [31:0] lfsr_q = 32'h9342;
  int          value_errs = 0;
  int          other_errs = 0;
  int          trap_seen = 0;
  trap_cause_e cause_log [$];
  ctx_t        model_q [$];

  nts_top UUT (
    .clk          (clk),
    .rst_i        (rst_i),
    .ext_irq_a_i  (ext_irq_a_i),
    .sft_irq_a_i  (sft_irq_a_i),
    .tmr_irq_a_i  (tmr_irq_a_i),
    .mie_i        (mie_i),
    .pc_i         (pc_i),
    .mstatus_i    (mstatus_i),
    .mret_i       (mret_i),
    .trap_o       (trap_o),
    .trap_cause_o (trap_cause_o),
    .ret_valid_o  (ret_valid_o),
    .ret_epc_o    (ret_epc_o),
    .ret_cause_o  (ret_cause_o),
    .ret_status_o (ret_status_o),
    .ret_err_o    (ret_err_o),
    .nts_full_o   (nts_full_o),
    .nts_depth_o  (nts_depth_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // galois lfsr stepped once per bit
  function automatic logic lfsr_step();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb)
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // external first, then software, then timer
  function automatic logic [2:0] pick_source(input logic [2:0] pend);
    if (pend[0])
      return 3'b001;
    if (pend[1])
      return 3'b010;
    if (pend[2])
      return 3'b100;
    return 3'b000;
  endfunction

  // context the stack must save for a trap from src
  function automatic ctx_t expected_trap(input logic [2:0] src, input xlen_t pc,
                                         input xlen_t st);
    ctx_t c;
    case (src)
      3'b001:  c.cause = CAUSE_MEI;
      3'b010:  c.cause = CAUSE_MSI;
      default: c.cause = CAUSE_MTI;
    endcase
    c.epc    = pc;
    c.status = st;
    return c;
  endfunction

  function automatic logic strobe_of(input int sel);
    case (sel)
      0:       return trap_o;
      1:       return ret_valid_o;
      default: return ret_err_o;
    endcase
  endfunction

  task automatic log_mismatch(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    value_errs++;
  endtask

  task automatic log_failure(input string msg);
    $display("%s at %0t", msg, $time);
    other_errs++;
  endtask

  // advance one clock and draw a new random context
  task automatic tick();
    @(posedge clk);
    pc_i      <= xlen_t'(rand_bits(`NTS_XLEN));
    mstatus_i <= xlen_t'(rand_bits(`NTS_XLEN));
  endtask

  task automatic pulse_irqs(input logic [2:0] mask);
    tick();
    ext_irq_a_i <= mask[0];
    sft_irq_a_i <= mask[1];
    tmr_irq_a_i <= mask[2];
    tick();
    tick();
    ext_irq_a_i <= 1'b0;
    sft_irq_a_i <= 1'b0;
    tmr_irq_a_i <= 1'b0;
  endtask

  task automatic do_mret();
    tick();
    mret_i <= 1'b1;
    tick();
    mret_i <= 1'b0;
  endtask

  // sel 0 trap_o, 1 ret_valid_o, 2 ret_err_o
  task automatic wait_strobe(input int sel, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (strobe_of(sel) !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (strobe_of(sel) === 1'b1)
    else log_failure({"timed out waiting for ", what});
    tick();
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model and comparison
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : check_outputs
    logic [2:0] hist [SYNC+2];
    logic [2:0] exp_pend;
    logic [2:0] src;
    logic       take;
    logic       exp_valid;
    logic       exp_err;
    ctx_t       exp_ctx;
    ctx_t       ctx;
    if (rst_i) begin
      for (int i = 0; i < SYNC + 2; i++) begin
        hist[i] = '0;
      end
      exp_pend  = '0;
      exp_valid = 1'b0;
      exp_err   = 1'b0;
    end else begin
      // strobes owed by last cycle's mret
      assert (ret_valid_o === exp_valid)
      else log_mismatch("ret_valid_o", 32'(ret_valid_o), 32'(exp_valid));
      assert (ret_err_o === exp_err)
      else log_mismatch("ret_err_o", 32'(ret_err_o), 32'(exp_err));
      if (exp_valid) begin
        assert (ret_cause_o === exp_ctx.cause)
        else log_mismatch("ret_cause_o", 32'(ret_cause_o), 32'(exp_ctx.cause));
        assert (ret_epc_o === exp_ctx.epc)
        else log_mismatch("ret_epc_o", 32'(ret_epc_o), 32'(exp_ctx.epc));
        assert (ret_status_o === exp_ctx.status)
        else log_mismatch("ret_status_o", 32'(ret_status_o), 32'(exp_ctx.status));
      end
      assert (nts_depth_o === depth_t'(model_q.size()))
      else log_mismatch("nts_depth_o", 32'(nts_depth_o), 32'(model_q.size()));
      assert (nts_full_o === (model_q.size() == DEPTH))
      else log_mismatch("nts_full_o", 32'(nts_full_o), 32'(model_q.size() == DEPTH));

      take = (|exp_pend) && mie_i && (model_q.size() < DEPTH) && !mret_i;
      assert (trap_o === take)
      else log_mismatch("trap_o", 32'(trap_o), 32'(take));
      src = 3'b000;
      if (take) begin
        src = pick_source(exp_pend);
        ctx = expected_trap(src, pc_i, mstatus_i);
        assert (trap_cause_o === ctx.cause)
        else log_mismatch("trap_cause_o", 32'(trap_cause_o), 32'(ctx.cause));
        model_q.push_back(ctx);
      end

      // traps as the DUT reports them
      if (trap_o === 1'b1) begin
        cause_log.push_back(trap_cause_o);
        trap_seen++;
      end

      exp_valid = 1'b0;
      exp_err   = 1'b0;
      if (mret_i) begin
        if (model_q.size() > 0) begin
          exp_ctx   = model_q.pop_back();
          exp_valid = 1'b1;
        end else begin
          exp_err = 1'b1;
        end
      end

      // an edge driven SYNC cycles ago becomes pending next cycle
      for (int i = SYNC + 1; i > 0; i--) begin
        hist[i] = hist[i-1];
      end
      hist[0]  = {tmr_irq_a_i, sft_irq_a_i, ext_irq_a_i};
      exp_pend = (exp_pend & ~src) | (hist[SYNC] & ~hist[SYNC+1]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int base;
    rst_i       = 1'b1;
    ext_irq_a_i = 1'b0;
    sft_irq_a_i = 1'b0;
    tmr_irq_a_i = 1'b0;
    mie_i       = 1'b0;
    mret_i      = 1'b0;
    repeat (10) tick();
    rst_i <= 1'b0;

    // single interrupt and its return
    tick();
    mie_i <= 1'b1;
    base = trap_seen;
    pulse_irqs(3'b010);
    wait_strobe(0, "single trap");
    repeat (4) tick();
    assert (trap_seen == base + 1)
    else log_failure("one edge did not give exactly one trap");
    do_mret();
    wait_strobe(1, "single restore");

    // priority with all three pending while masked
    tick();
    mie_i <= 1'b0;
    base = trap_seen;
    pulse_irqs(3'b111);
    repeat (8) tick();
    assert (trap_seen == base)
    else log_failure("trap taken while interrupts were masked");
    mie_i <= 1'b1;
    repeat (3) wait_strobe(0, "priority trap");
    assert (cause_log.size() >= 3 && cause_log[$-2] == CAUSE_MEI &&
            cause_log[$-1] == CAUSE_MSI && cause_log[$] == CAUSE_MTI)
    else log_failure("traps did not arrive in priority order");
    repeat (3) begin
      do_mret();
      wait_strobe(1, "priority restore");
    end

    // masking a single timer edge
    tick();
    mie_i <= 1'b0;
    base = trap_seen;
    pulse_irqs(3'b100);
    repeat (8) tick();
    assert (trap_seen == base)
    else log_failure("masked timer edge gave a trap");
    mie_i <= 1'b1;
    wait_strobe(0, "trap after unmasking");
    do_mret();
    wait_strobe(1, "masking restore");

    // fill the stack and send one more edge
    for (int i = 0; i < DEPTH; i++) begin
      pulse_irqs(3'b001 << (i % 3));
      wait_strobe(0, "fill trap");
    end
    @(negedge clk);
    assert (nts_full_o === 1'b1)
    else log_failure("stack did not report full after filling it");
    base = trap_seen;
    pulse_irqs(3'b100);
    repeat (8) tick();
    assert (trap_seen == base)
    else log_failure("trap taken while the stack was full");
    do_mret();
    wait_strobe(0, "trap after room freed");
    repeat (DEPTH) begin
      do_mret();
      wait_strobe(1, "drain restore");
    end

    // return on an empty stack
    @(negedge clk);
    assert (nts_depth_o == 0)
    else log_failure("stack not empty before the empty return");
    do_mret();
    wait_strobe(2, "empty-return error");
    @(negedge clk);
    assert (nts_depth_o == 0)
    else log_failure("depth moved after the empty return");

    // random interleaving
    for (int i = 0; i < RAND_CYCLES; i++) begin
      tick();
      ext_irq_a_i <= (rand_bits(2) == 32'd0);
      sft_irq_a_i <= (rand_bits(2) == 32'd0);
      tmr_irq_a_i <= (rand_bits(2) == 32'd0);
      mie_i       <= |rand_bits(2);
      mret_i      <= (rand_bits(3) == 32'd0);
    end
    tick();
    ext_irq_a_i <= 1'b0;
    sft_irq_a_i <= 1'b0;
    tmr_irq_a_i <= 1'b0;
    mret_i      <= 1'b0;
    mie_i       <= 1'b1;
    repeat (8) tick();
    repeat (3 * DEPTH) begin
      do_mret();
      tick();
    end
    @(negedge clk);
    assert (nts_depth_o == 0)
    else log_failure("stack not drained after the random run");

    tick();
    $display("error counts: %0d value mismatches, %0d other failures",
             value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* hw/nts_top.sv */
`timescale 1ns/1ps

`include "nts_settings.svh"

module nts_top
  import nts_pkg::*;
(
  input  logic        clk,
  input  logic        rst_i,
  input  logic        ext_irq_a_i,
  input  logic        sft_irq_a_i,
  input  logic        tmr_irq_a_i,
  input  logic        mie_i,
  input  xlen_t       pc_i,
  input  xlen_t       mstatus_i,
  input  logic        mret_i,
  output logic        trap_o,
  output trap_cause_e trap_cause_o,
  output logic        ret_valid_o,
  output xlen_t       ret_epc_o,
  output trap_cause_e ret_cause_o,
  output xlen_t       ret_status_o,
  output logic        ret_err_o,
  output logic        nts_full_o,
  output depth_t      nts_depth_o
);

  // arbiter to stack
  logic        push;
  trap_cause_e push_cause;
  xlen_t       push_epc;
  xlen_t       push_status;

  // stack to return controller
  logic        pop;
  logic        empty;
  trap_cause_e top_cause;
  xlen_t       top_epc;
  xlen_t       top_status;

  //////////////////////////////////////////////////////////////////////
  // trap side
  //////////////////////////////////////////////////////////////////////

  trap_arbiter u_trap_arbiter (
    .clk           (clk),
    .rst_i         (rst_i),
    .ext_irq_a_i   (ext_irq_a_i),
    .sft_irq_a_i   (sft_irq_a_i),
    .tmr_irq_a_i   (tmr_irq_a_i),
    .mie_i         (mie_i),
    .mret_i        (mret_i),
    .full_i        (nts_full_o),
    .pc_i          (pc_i),
    .mstatus_i     (mstatus_i),
    .push_o        (push),
    .push_cause_o  (push_cause),
    .push_epc_o    (push_epc),
    .push_status_o (push_status)
  );

  assign trap_o       = push;
  assign trap_cause_o = push_cause;

  //////////////////////////////////////////////////////////////////////
  // context stack
  //////////////////////////////////////////////////////////////////////

  nts_stack #(
    .DEPTH (`NTS_DEPTH)
  ) u_nts_stack (
    .clk           (clk),
    .rst_i         (rst_i),
    .push_i        (push),
    .push_cause_i  (push_cause),
    .push_epc_i    (push_epc),
    .push_status_i (push_status),
    .pop_i         (pop),
    .top_cause_o   (top_cause),
    .top_epc_o     (top_epc),
    .top_status_o  (top_status),
    .full_o        (nts_full_o),
    .empty_o       (empty),
    .depth_o       (nts_depth_o)
  );

  //////////////////////////////////////////////////////////////////////
  // return side
  //////////////////////////////////////////////////////////////////////

  nts_ret_ctrl u_nts_ret_ctrl (
    .clk          (clk),
    .rst_i        (rst_i),
    .mret_i       (mret_i),
    .empty_i      (empty),
    .top_cause_i  (top_cause),
    .top_epc_i    (top_epc),
    .top_status_i (top_status),
    .pop_o        (pop),
    .ret_valid_o  (ret_valid_o),
    .ret_cause_o  (ret_cause_o),
    .ret_epc_o    (ret_epc_o),
    .ret_status_o (ret_status_o),
    .ret_err_o    (ret_err_o)
  );

endmodule

/* hw/nts_ret_ctrl.sv */
`timescale 1ns/1ps

`include "nts_settings.svh"

module nts_ret_ctrl
  import nts_pkg::*;
(
  input  logic        clk,
  input  logic        rst_i,
  input  logic        mret_i,
  input  logic        empty_i,
  input  trap_cause_e top_cause_i,
  input  xlen_t       top_epc_i,
  input  xlen_t       top_status_i,
  output logic        pop_o,
  output logic        ret_valid_o,
  output trap_cause_e ret_cause_o,
  output xlen_t       ret_epc_o,
  output xlen_t       ret_status_o,
  output logic        ret_err_o
);

  logic ret_valid_q;
  logic ret_err_q;

  // pop in the mret cycle itself
  assign pop_o = mret_i & ~empty_i;

  //////////////////////////////////////////////////////////////////////
  // restore strobes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ret_valid_q <= 1'b0;
      ret_err_q   <= 1'b0;
    end else begin
      ret_valid_q <= pop_o;
      ret_err_q   <= mret_i & empty_i;
    end
  end

  // restored context, held until the next pop
  always_ff @(posedge clk) begin
    if (pop_o) begin
      ret_cause_o  <= top_cause_i;
      ret_epc_o    <= top_epc_i;
      ret_status_o <= top_status_i;
    end
  end

  assign ret_valid_o = ret_valid_q;
  assign ret_err_o   = ret_err_q;

endmodule

/* hw/nts_stack.sv */
`timescale 1ns/1ps

`include "nts_settings.svh"

module nts_stack
  import nts_pkg::*;
#(
  parameter int DEPTH = `NTS_DEPTH
) (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        push_i,
  input  trap_cause_e push_cause_i,
  input  xlen_t       push_epc_i,
  input  xlen_t       push_status_i,
  input  logic        pop_i,
  output trap_cause_e top_cause_o,
  output xlen_t       top_epc_o,
  output xlen_t       top_status_o,
  output logic        full_o,
  output logic        empty_o,
  output depth_t      depth_o
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  //////////////////////////////////////////////////////////////////////
  // context storage
  //////////////////////////////////////////////////////////////////////

  trap_cause_e cause_mem  [DEPTH];
  xlen_t       epc_mem    [DEPTH];
  xlen_t       status_mem [DEPTH];

  depth_t           cnt_q;
  depth_t           cnt_m1;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] top_idx;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (cnt_q == depth_t'(DEPTH));
  assign empty_o = (cnt_q == '0);

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign cnt_m1  = cnt_q - depth_t'(1);
  assign wr_idx  = cnt_q[IDX_W-1:0];
  // slot 0 is shown while empty and nobody reads it then
  assign top_idx = empty_o ? '0 : cnt_m1[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (do_push) begin
      cause_mem[wr_idx]  <= push_cause_i;
      epc_mem[wr_idx]    <= push_epc_i;
      status_mem[wr_idx] <= push_status_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // fill count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (do_push) begin
      cnt_q <= cnt_q + depth_t'(1);
    end else if (do_pop) begin
      cnt_q <= cnt_m1;
    end
  end

  assign depth_o = cnt_q;

  // newest entry is read without a clock
  assign top_cause_o  = cause_mem[top_idx];
  assign top_epc_o    = epc_mem[top_idx];
  assign top_status_o = status_mem[top_idx];

endmodule

/* hw/trap_arbiter.sv */
`timescale 1ns/1ps

`include "nts_settings.svh"

module trap_arbiter
  import nts_pkg::*;
(
  input  logic        clk,
  input  logic        rst_i,
  input  logic        ext_irq_a_i,
  input  logic        sft_irq_a_i,
  input  logic        tmr_irq_a_i,
  input  logic        mie_i,
  input  logic        mret_i,
  input  logic        full_i,
  input  xlen_t       pc_i,
  input  xlen_t       mstatus_i,
  output logic        push_o,
  output trap_cause_e push_cause_o,
  output xlen_t       push_epc_o,
  output xlen_t       push_status_o
);

  localparam int SYNC_STAGES = `NTS_SYNC_STAGES;

  // bit 0 external, bit 1 software, bit 2 timer
  logic [2:0] irq_a;
  logic [2:0] sync_q [SYNC_STAGES];
  logic [2:0] irq_d_q;
  logic [2:0] irq_rise;
  logic [2:0] pend_q;
  logic [2:0] grant;
  logic       take;

  assign irq_a = {tmr_irq_a_i, sft_irq_a_i, ext_irq_a_i};

  //////////////////////////////////////////////////////////////////////
  // synchronizer and edge detect
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
      irq_d_q <= '0;
    end else begin
      sync_q[0] <= irq_a;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      irq_d_q <= sync_q[SYNC_STAGES-1];
    end
  end

  // high for one cycle after the last sync stage goes high
  assign irq_rise = sync_q[SYNC_STAGES-1] & ~irq_d_q;

  //////////////////////////////////////////////////////////////////////
  // pending bits and priority pick
  //////////////////////////////////////////////////////////////////////

  // no trap while a return is in flight, so push and pop never collide
  assign take = (|pend_q) & mie_i & ~full_i & ~mret_i;

  always_comb begin
    grant        = 3'b000;
    push_cause_o = CAUSE_MEI;
    if (pend_q[0]) begin
      grant        = 3'b001;
      push_cause_o = CAUSE_MEI;
    end else if (pend_q[1]) begin
      grant        = 3'b010;
      push_cause_o = CAUSE_MSI;
    end else if (pend_q[2]) begin
      grant        = 3'b100;
      push_cause_o = CAUSE_MTI;
    end
  end

  // a fresh edge in the take cycle starts a new trap
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pend_q <= '0;
    end else if (take) begin
      pend_q <= (pend_q & ~grant) | irq_rise;
    end else begin
      pend_q <= pend_q | irq_rise;
    end
  end

  assign push_o        = take;
  // context is captured by the stack on the same edge
  assign push_epc_o    = pc_i;
  assign push_status_o = mstatus_i;

endmodule

/* hw/nts_pkg.sv */
`include "nts_settings.svh"

package nts_pkg;

  //////////////////////////////////////////////////////////////////////
  // trap causes
  //////////////////////////////////////////////////////////////////////

  // machine interrupt codes as written to mcause
  typedef enum logic [3:0] {
    CAUSE_MSI = 4'd3,
    CAUSE_MTI = 4'd7,
    CAUSE_MEI = 4'd11
  } trap_cause_e;

  //////////////////////////////////////////////////////////////////////
  // data and count types
  //////////////////////////////////////////////////////////////////////

  // pc and mstatus word
  typedef logic [`NTS_XLEN-1:0] xlen_t;

  // fill level, 0 up to and including NTS_DEPTH
  typedef logic [$clog2(`NTS_DEPTH + 1)-1:0] depth_t;

endpackage

/* include/nts_settings.svh */
`ifndef NTS_SETTINGS_SVH
`define NTS_SETTINGS_SVH

// width of the saved pc and status words
`define NTS_XLEN 32

// number of nested contexts the stack can hold
`define NTS_DEPTH 4

// flops per asynchronous interrupt line
`define NTS_SYNC_STAGES 2

`endif
